/* hdl/alu.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module alu (
  input  logic [`RV_XLEN-1:0]  a,
  input  logic [`RV_XLEN-1:0]  b,
  input  rv_core_pkg::alu_op_e alu_op,
  output logic [`RV_XLEN-1:0]  result,
  output logic                 eq
);
  import rv_core_pkg::*;

  always_comb begin
    case (alu_op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      // signed compare, result is 0 or 1
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // branch compare, independent of alu_op
  assign eq = (a == b);

endmodule

/* hdl/core_control.sv */
`timescale 1ns/1ps

module core_control (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [31:0]            inst,
  output rv_core_pkg::alu_op_e   alu_op,
  output rv_core_pkg::imm_fmt_e  imm_fmt,
  output rv_core_pkg::wb_sel_e   wb_sel,
  output rv_core_pkg::mem_size_e mem_size,
  output logic                   alu_src_pc,
  output logic                   alu_src_imm,
  output logic                   reg_wen,
  output logic                   mem_ren,
  output logic                   mem_wen,
  output logic                   mem_unsigned,
  output logic                   branch,
  output logic                   branch_ne,
  output logic                   jump,
  output logic                   jump_reg,
  output logic                   halt
);
  import rv_core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic       reg_wen_dec;
  logic       mem_wen_dec;
  logic       is_ebreak;
  logic       halted_q;

  assign opcode    = opcode_e'(inst[6:0]);
  assign funct3    = inst[14:12];
  assign funct7_b5 = inst[30];

  always_comb begin
    alu_op       = ALU_ADD;
    imm_fmt      = IMM_I;
    wb_sel       = WB_ALU;
    mem_size     = SIZE_W;
    alu_src_pc   = 1'b0;
    alu_src_imm  = 1'b0;
    reg_wen_dec  = 1'b0;
    mem_ren      = 1'b0;
    mem_wen_dec  = 1'b0;
    mem_unsigned = 1'b0;
    branch       = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    jump_reg     = 1'b0;
    is_ebreak    = 1'b0;
    case (opcode)
      OP_IMM, OP_REG: begin
        alu_src_imm = (opcode == OP_IMM);
        reg_wen_dec = 1'b1;
        case (funct3)
          // bit 30 selects sub only for register form
          3'b000:  alu_op = (opcode == OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: reg_wen_dec = 1'b0;
        endcase
      end
      OP_LUI: begin
        imm_fmt     = IMM_U;
        alu_src_imm = 1'b1;
        alu_op      = ALU_PASS_B;
        reg_wen_dec = 1'b1;
      end
      OP_AUIPC: begin
        imm_fmt     = IMM_U;
        alu_src_pc  = 1'b1;
        alu_src_imm = 1'b1;
        reg_wen_dec = 1'b1;
      end
      OP_JAL: begin
        imm_fmt     = IMM_J;
        wb_sel      = WB_PC4;
        jump        = 1'b1;
        reg_wen_dec = 1'b1;
      end
      OP_JALR: begin
        alu_src_imm = 1'b1;
        wb_sel      = WB_PC4;
        jump_reg    = (funct3 == 3'b000);
        reg_wen_dec = (funct3 == 3'b000);
      end
      OP_BRANCH: begin
        // eq flag comes from rs1 vs rs2
        imm_fmt   = IMM_B;
        alu_op    = ALU_SUB;
        branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
        branch_ne = (funct3 == 3'b001);
      end
      OP_LOAD: begin
        alu_src_imm  = 1'b1;
        wb_sel       = WB_MEM;
        mem_size     = mem_size_e'(funct3[1:0]);
        mem_unsigned = funct3[2];
        case (funct3)
          3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin
            mem_ren     = 1'b1;
            reg_wen_dec = 1'b1;
          end
          default: ;
        endcase
      end
      OP_STORE: begin
        imm_fmt     = IMM_S;
        alu_src_imm = 1'b1;
        mem_size    = mem_size_e'(funct3[1:0]);
        mem_wen_dec = !funct3[2] && (funct3[1:0] != 2'b11);
      end
      OP_SYSTEM: begin
        // only ebreak, ecall and the rest fall through as nops
        is_ebreak = (inst[31:7] == 25'h000_2000);
      end
      default: ;
    endcase
  end

  // sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted_q <= 1'b0;
    end else if (is_ebreak) begin
      halted_q <= 1'b1;
    end
  end

  assign reg_wen = reg_wen_dec && !halted_q;
  assign mem_wen = mem_wen_dec && !halted_q;
  assign halt    = halted_q;

  a_no_ren_wen: assert property (@(posedge clk) disable iff (!rst_n) !(mem_ren && mem_wen))
    else $error("load and store strobes high in the same cycle");

endmodule

/* hdl/imm_gen.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module imm_gen (
  input  logic [31:0]           inst,
  input  rv_core_pkg::imm_fmt_e imm_fmt,
  output logic [`RV_XLEN-1:0]   imm
);
  import rv_core_pkg::*;

  logic sign;

  assign sign = inst[31];

  always_comb begin
    case (imm_fmt)
      IMM_I: imm = {{20{sign}}, inst[31:20]};
      IMM_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
      // bit 0 always zero for branch and jump offsets
      IMM_B: imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U: imm = {inst[31:12], 12'h000};
      IMM_J: imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module load_store_unit (
  input  logic [`RV_XLEN-1:0]    addr,
  input  logic [`RV_XLEN-1:0]    store_data,
  input  rv_core_pkg::mem_size_e mem_size,
  input  logic                   mem_unsigned,
  input  logic                   mem_ren,
  input  logic                   mem_wen,
  input  logic [`RV_XLEN-1:0]    dmem_rdata,
  output logic [`RV_XLEN-1:0]    dmem_addr,
  output logic [`RV_XLEN-1:0]    dmem_wdata,
  output logic [3:0]             dmem_wmask,
  output logic                   dmem_ren,
  output logic                   dmem_wen,
  output logic [`RV_XLEN-1:0]    load_data
);
  import rv_core_pkg::*;

  logic [1:0]          byte_off;
  logic [`RV_XLEN-1:0] rdata_shifted;

  assign byte_off  = addr[1:0];
  assign dmem_addr = {addr[`RV_XLEN-1:2], 2'b00};
  assign dmem_ren  = mem_ren;
  assign dmem_wen  = mem_wen;

  // replicate narrow data so every lane carries it, mask picks the lane
  always_comb begin
    case (mem_size)
      SIZE_B: begin
        dmem_wdata = {4{store_data[7:0]}};
        dmem_wmask = 4'b0001 << byte_off;
      end
      SIZE_H: begin
        dmem_wdata = {2{store_data[15:0]}};
        dmem_wmask = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      SIZE_W: begin
        dmem_wdata = store_data;
        dmem_wmask = 4'b1111;
      end
      default: begin
        dmem_wdata = store_data;
        dmem_wmask = 4'b0000;
      end
    endcase
  end

  // bring the addressed lane down to bit 0
  assign rdata_shifted = dmem_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (mem_size)
      SIZE_B: begin
        load_data = {{24{!mem_unsigned && rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      SIZE_H: begin
        load_data = {{16{!mem_unsigned && rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      default: begin
        load_data = dmem_rdata;
      end
    endcase
  end

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module pc_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                halt,
  input  logic                branch,
  input  logic                branch_ne,
  input  logic                jump,
  input  logic                jump_reg,
  input  logic                eq,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] alu_result,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4
);

  logic                taken;
  logic [`RV_XLEN-1:0] pc_next;

  // bne inverts the equality flag
  assign taken    = branch && (eq ^ branch_ne);
  assign pc_plus4 = pc + `RV_XLEN'd4;

  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (jump_reg) begin
      pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else if (jump || taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module reg_file (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [$clog2(`RV_NUM_REGS)-1:0]    rs1_addr,
  input  logic [$clog2(`RV_NUM_REGS)-1:0]    rs2_addr,
  input  logic [$clog2(`RV_NUM_REGS)-1:0]    rd_addr,
  input  logic                               wen,
  input  logic [`RV_XLEN-1:0]                wdata,
  output logic [`RV_XLEN-1:0]                rs1_data,
  output logic [`RV_XLEN-1:0]                rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // x0 is never written, so it keeps the reset value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata;
    end
  end

  // combinational read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (rs1_addr == '0) |-> (rs1_data == '0))
    else $error("x0 read back non-zero");

endmodule

/* hdl/rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// pc value loaded on reset
`define RV_RESET_PC 32'h8000_0000

// data path width
`define RV_XLEN 32

// architectural registers, addressed with 5 bits
`define RV_NUM_REGS 32

`endif

/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

  // base opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b000_0011,
    OP_IMM    = 7'b001_0011,
    OP_AUIPC  = 7'b001_0111,
    OP_STORE  = 7'b010_0011,
    OP_REG    = 7'b011_0011,
    OP_LUI    = 7'b011_0111,
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  // encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SIZE_B = 2'b00,
    SIZE_H = 2'b01,
    SIZE_W = 2'b10
  } mem_size_e;

endpackage

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         inst,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic [3:0]          dmem_wmask,
  output logic                dmem_ren,
  output logic                dmem_wen,
  output logic                halt
);
  import rv_core_pkg::*;

  alu_op_e             alu_op;
  imm_fmt_e            imm_fmt;
  wb_sel_e             wb_sel;
  mem_size_e           mem_size;
  logic                alu_src_pc;
  logic                alu_src_imm;
  logic                reg_wen;
  logic                mem_ren;
  logic                mem_wen;
  logic                mem_unsigned;
  logic                branch;
  logic                branch_ne;
  logic                jump;
  logic                jump_reg;
  logic                eq;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] load_data;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] wb_data;

  core_control control_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .alu_op       (alu_op),
    .imm_fmt      (imm_fmt),
    .wb_sel       (wb_sel),
    .mem_size     (mem_size),
    .alu_src_pc   (alu_src_pc),
    .alu_src_imm  (alu_src_imm),
    .reg_wen      (reg_wen),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .mem_unsigned (mem_unsigned),
    .branch       (branch),
    .branch_ne    (branch_ne),
    .jump         (jump),
    .jump_reg     (jump_reg),
    .halt         (halt)
  );

  imm_gen imm_gen_i (
    .inst    (inst),
    .imm_fmt (imm_fmt),
    .imm     (imm)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (inst[19:15]),
    .rs2_addr (inst[24:20]),
    .rd_addr  (inst[11:7]),
    .wen      (reg_wen),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // auipc takes pc, loads/stores/jalr/addi take the immediate
  assign alu_a = alu_src_pc ? pc : rs1_data;
  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu alu_i (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_result),
    .eq     (eq)
  );

  load_store_unit lsu_i (
    .addr         (alu_result),
    .store_data   (rs2_data),
    .mem_size     (mem_size),
    .mem_unsigned (mem_unsigned),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .dmem_rdata   (dmem_rdata),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_wmask   (dmem_wmask),
    .dmem_ren     (dmem_ren),
    .dmem_wen     (dmem_wen),
    .load_data    (load_data)
  );

  pc_unit pc_unit_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .halt       (halt),
    .branch     (branch),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .jump_reg   (jump_reg),
    .eq         (eq),
    .imm        (imm),
    .alu_result (alu_result),
    .pc         (pc),
    .pc_plus4   (pc_plus4)
  );

  // write-back select
  always_comb begin
    case (wb_sel)
      WB_MEM:  wb_data = load_data;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  // address from the alu must suit the access size picked by decode
  a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_ren || mem_wen) |->
      !((mem_size == SIZE_H) && alu_result[0]) &&
      !((mem_size == SIZE_W) && (alu_result[1:0] != 2'b00)))
    else $error("misaligned data access at %h", alu_result);

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module rv_core_tb -f verilog.f -Mdir obj_dir -o rv_core_sim \
  && ./obj_dir/rv_core_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"
grep -q "SIMULATION PASSED" sim.log && echo "run ok" && exit 0 \
  || { echo "run not ok, see sim.log"; exit 1; }

/* tb/clk_rst_gen.sv */
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // release on a rising edge so the first instruction lines up with it
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core_tb;
  import rv_core_pkg::*;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic        st;
    logic        ld;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic        halt;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] dmem_rdata = '0;
  logic [31:0] pc;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wmask;
  logic        dmem_ren;
  logic        dmem_wen;
  logic        halt;

  step_t       steps [96];
  int          n_steps = 0;
  int          errors = 0;
  int          checks = 0;
  int          seed = 32'h58a2_365f;
  int unsigned mem_version = 0;
  logic [31:0] cur_pc;
  logic        exp_halted;
  logic [11:0] store_off;
  logic [31:0] dmem [logic [31:0]];

  clk_rst_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  rv_core_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .halt       (halt)
  );

  // instruction encoders, straight from the isa field layout
  function automatic logic [31:0] i_type(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(opcode_e op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // unwritten words return a pattern built from the full address
  function automatic logic [31:0] mem_read(logic [31:0] addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  task automatic write_masked(logic [31:0] addr, logic [31:0] data, logic [3:0] mask);
    logic [31:0] word;
    word = mem_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    dmem[addr] = word;
    mem_version++;
  endtask

  // rv32i load result for funct3 at a byte address
  function automatic logic [31:0] load_value(logic [2:0] f3, logic [31:0] addr);
    logic [31:0] lane;
    lane = mem_read({addr[31:2], 2'b00}) >> {addr[1:0], 3'b000};
    case (f3)
      3'b000:  return {{24{lane[7]}}, lane[7:0]};
      3'b100:  return {24'h0, lane[7:0]};
      3'b001:  return {{16{lane[15]}}, lane[15:0]};
      3'b101:  return {16'h0, lane[15:0]};
      default: return lane;
    endcase
  endfunction

  function automatic logic [31:0] byte_lanes(logic [3:0] mask);
    return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s exp=%h got=%h", name, exp, got);
    end
  endtask

  // pc only advances in the table while the core is running
  task automatic add_step(logic [31:0] word, logic [31:0] next_pc, logic st, logic ld,
                          logic [31:0] addr, logic [31:0] wdata, logic [3:0] mask);
    steps[n_steps] = '{word, cur_pc, st, ld, addr, wdata, mask, exp_halted};
    n_steps++;
    if (!exp_halted) begin
      cur_pc = next_pc;
    end
  endtask

  task automatic plain_step(logic [31:0] word);
    add_step(word, cur_pc + 32'd4, 1'b0, 1'b0, '0, '0, 4'h0);
  endtask

  task automatic flow_step(logic [31:0] word, logic [31:0] target);
    add_step(word, target, 1'b0, 1'b0, '0, '0, 4'h0);
  endtask

  task automatic store_step(logic [31:0] word, logic [31:0] addr, logic [31:0] wdata,
                            logic [3:0] mask);
    add_step(word, cur_pc + 32'd4, 1'b1, 1'b0, addr, wdata, mask);
  endtask

  task automatic load_step(logic [31:0] word, logic [31:0] addr);
    add_step(word, cur_pc + 32'd4, 1'b0, 1'b1, addr, '0, 4'h0);
  endtask

  // sw into the result area at x10 + running offset
  task automatic expose_reg(logic [4:0] rs2, logic [31:0] value);
    store_step(s_type(3'b010, 5'd10, rs2, store_off), 32'h1000 + {20'h0, store_off},
               value, 4'b1111);
    store_off = store_off + 12'd4;
  endtask

  task automatic load_expose(logic [2:0] f3, logic [11:0] off);
    logic [31:0] addr;
    addr = 32'h2000 + {20'h0, off};
    load_step(i_type(OP_LOAD, f3, 5'd14, 5'd13, off), {addr[31:2], 2'b00});
    expose_reg(5'd14, load_value(f3, addr));
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] auipc_val;
    logic [31:0] link;
    logic [31:0] base;
    a = 32'h0000_0123;
    b = 32'hffff_fffa;
    cur_pc = `RV_RESET_PC;
    exp_halted = 1'b0;
    store_off = 12'h000;
    // arithmetic
    plain_step(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, 12'h123));
    plain_step(i_type(OP_IMM, 3'b000, 5'd2, 5'd0, 12'hffa));
    plain_step(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    plain_step(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    plain_step(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    plain_step(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    plain_step(r_type(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
    plain_step(r_type(7'h00, 3'b010, 5'd8, 5'd2, 5'd1));
    plain_step(r_type(7'h00, 3'b010, 5'd9, 5'd1, 5'd2));
    plain_step(u_type(OP_LUI, 5'd10, 20'h00001));
    auipc_val = cur_pc + 32'h1234_5000;
    plain_step(u_type(OP_AUIPC, 5'd11, 20'h12345));
    plain_step(i_type(OP_IMM, 3'b000, 5'd0, 5'd1, 12'h7ff));
    expose_reg(5'd3, a + b);
    expose_reg(5'd4, a - b);
    expose_reg(5'd5, a & b);
    expose_reg(5'd6, a | b);
    expose_reg(5'd7, a ^ b);
    expose_reg(5'd8, {31'h0, $signed(b) < $signed(a)});
    expose_reg(5'd9, {31'h0, $signed(a) < $signed(b)});
    expose_reg(5'd10, 32'h0000_1000);
    expose_reg(5'd11, auipc_val);
    expose_reg(5'd0, 32'h0);
    // byte and half stores of 0x11223344
    plain_step(u_type(OP_LUI, 5'd12, 20'h11223));
    plain_step(i_type(OP_IMM, 3'b000, 5'd12, 5'd12, 12'h344));
    for (int k = 0; k < 4; k++) begin
      store_step(s_type(3'b000, 5'd10, 5'd12, 12'(12'h100 + k)), 32'h1100,
                 32'h44 << (8 * k), 4'b0001 << k);
    end
    store_step(s_type(3'b001, 5'd10, 5'd12, 12'h108), 32'h1108, 32'h0000_3344, 4'b0011);
    store_step(s_type(3'b001, 5'd10, 5'd12, 12'h10a), 32'h1108, 32'h3344_0000, 4'b1100);
    // loads from the seeded words at 0x2000
    plain_step(u_type(OP_LUI, 5'd13, 20'h00002));
    load_expose(3'b000, 12'h001);
    load_expose(3'b100, 12'h003);
    load_expose(3'b001, 12'h002);
    load_expose(3'b101, 12'h000);
    load_expose(3'b010, 12'h004);
    load_expose(3'b000, 12'h006);
    load_expose(3'b101, 12'h006);
    // branches, taken and not, one backward
    flow_step(b_type(3'b000, 5'd1, 5'd1, 13'd8), cur_pc + 32'd8);
    flow_step(b_type(3'b000, 5'd1, 5'd2, 13'd8), cur_pc + 32'd4);
    flow_step(b_type(3'b001, 5'd1, 5'd2, 13'h1ff0), cur_pc - 32'd16);
    flow_step(b_type(3'b001, 5'd1, 5'd1, 13'd8), cur_pc + 32'd4);
    link = cur_pc + 32'd4;
    flow_step(j_type(5'd15, 21'd16), cur_pc + 32'd16);
    expose_reg(5'd15, link);
    base = cur_pc;
    plain_step(u_type(OP_AUIPC, 5'd17, 20'h00000));
    link = cur_pc + 32'd4;
    // odd offset, target bit 0 dropped
    flow_step(i_type(OP_JALR, 3'b000, 5'd16, 5'd17, 12'd13), (base + 32'd13) & ~32'd1);
    expose_reg(5'd16, link);
    // ebreak, then the core must stay put
    flow_step(32'h0010_0073, cur_pc + 32'd4);
    exp_halted = 1'b1;
    plain_step(s_type(3'b010, 5'd10, 5'd1, 12'h000));
    plain_step(i_type(OP_IMM, 3'b000, 5'd1, 5'd1, 12'h001));
    plain_step(j_type(5'd0, 21'd64));
    plain_step(s_type(3'b000, 5'd10, 5'd12, 12'h001));
  endtask

  // data memory, combinational read and masked write on the edge
  always @(dmem_addr or mem_version) begin
    dmem_rdata = mem_read(dmem_addr);
  end

  always @(posedge clk) begin
    if (rst_n && dmem_wen) begin
      write_masked(dmem_addr, dmem_wdata, dmem_wmask);
    end
  end

  initial begin
    wait (n_steps > 0);
    #((n_steps + 20) * 10);
    $display("timeout: the program did not finish within %0d clock cycles", n_steps + 20);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    inst = i_type(OP_IMM, 3'b000, 5'd0, 5'd0, 12'h000);
    // one word with every byte negative, one with every byte positive
    dmem[32'h2000] = $random(seed) | 32'h8080_8080;
    dmem[32'h2004] = $random(seed) & 32'h7f7f_7f7f;
    mem_version++;
    build_program();
    @(posedge rst_n);
    for (int i = 0; i < n_steps; i++) begin
      inst <= steps[i].inst;
      @(negedge clk);
      check_value($sformatf("pc[%0d]", i), steps[i].pc, pc);
      check_value($sformatf("halt[%0d]", i), {31'h0, steps[i].halt}, {31'h0, halt});
      check_value($sformatf("dmem_wen[%0d]", i), {31'h0, steps[i].st}, {31'h0, dmem_wen});
      check_value($sformatf("dmem_ren[%0d]", i), {31'h0, steps[i].ld}, {31'h0, dmem_ren});
      if (steps[i].st || steps[i].ld) begin
        check_value($sformatf("dmem_addr[%0d]", i), steps[i].addr, dmem_addr);
      end
      if (steps[i].st) begin
        check_value($sformatf("dmem_wmask[%0d]", i), {28'h0, steps[i].mask},
                    {28'h0, dmem_wmask});
        check_value($sformatf("dmem_wdata[%0d]", i),
                    steps[i].wdata & byte_lanes(steps[i].mask),
                    dmem_wdata & byte_lanes(steps[i].mask));
      end
      @(posedge clk);
    end
    $display("steps: %0d  checks: %0d  errors: %0d", n_steps, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/core_control.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/load_store_unit.sv
hdl/pc_unit.sv
hdl/rv_core_top.sv
tb/clk_rst_gen.sv
tb/rv_core_tb.sv
